// File: Bender.yml
package:
  name: cpu_pipeline

sources:
  - include_dirs:
      - source
    files:
      - source/cpu_isa_pkg.sv
      - source/cpu_pipe_pkg.sv
      - source/pipeline_sequencer.sv
      - source/fetch_pc.sv
      - source/pipeline_slots.sv
      - source/imm_tracker.sv
      - source/cpu_pipeline.sv
  - target: test
    files:
      - dv/cpu_pipeline_tb.sv

// File: dv/cpu_pipeline_tb.sv
// CPU pipeline testbench

`timescale 1ns/1ps
`default_nettype none

module cpu_pipeline_tb;

	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	localparam int CLK_PERIOD = 100;
	// Rough length of each test in cycles
	localparam int TEST_CYCLES = 2 + 20 + 30 + 30 + 30 + 20 + 20;
	localparam instr_t PREFIX_INSTR = 16'h1ABC;
	localparam instr_t USER_INSTR = 16'h6325;

	logic CLK;
	logic RSTb;
	logic hazard_1;
	logic hazard_2;
	logic hazard_3;
	reg_idx_t hazard_reg0;
	logic modifies_flags0;
	cache_line_t cache_line;
	logic cache_miss;
	mem_status_t mem;
	logic load_pc;
	instr_t new_pc;
	logic halt;
	logic interrupt;
	logic [3:0] irq;
	logic interrupt_flag_set;
	logic interrupt_flag_clear;
	instr_t pipeline_stage0;
	instr_t pipeline_stage1;
	instr_t pipeline_stage2;
	instr_t pipeline_stage3;
	instr_t pipeline_stage4;
	instr_t pc_stage4;
	hazard_tag_t hazard_tag1;
	hazard_tag_t hazard_tag2;
	hazard_tag_t hazard_tag3;
	instr_t imm_reg;
	word_addr_t cache_request_address;
	logic is_executing;

	// Cache model state
	instr_t program_mem [0:63];
	logic miss_map [0:63];
	logic miss_mode;
	word_addr_t last_request;
	cache_line_t taken;
	logic miss_seen;
	cache_line_t hist[$];
	hazard_tag_t tag_hist[$];
	logic [31:0] lcg_state;
	int checks;
	int errors;
	int misses;

	cpu_pipeline DUT (.*);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("FAILED %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// One clock; the cache answers the request of the cycle before
	task automatic next_cycle();
		taken = cache_line;
		miss_seen = cache_miss;
		@(posedge CLK);
		@(negedge CLK);
		cache_line = '{addr: last_request, spare: 1'b0,
			instr: program_mem[last_request[5:0]]};
		cache_miss = miss_mode && miss_map[last_request[5:0]];
		// A missed line is filled and hits from then on
		if (cache_miss) begin
			miss_map[last_request[5:0]] = 1'b0;
			misses++;
		end
		last_request = cache_request_address;
	endtask

	// Slot 0 follows the cache and slot 4 lags it by four cycles
	task automatic run_straight(input int warm, input int n);
		logic [31:0] rnd;

		hist.delete();
		tag_hist.delete();
		repeat (warm) next_cycle();
		repeat (n) begin
			// Fresh slot 0 hazard tag every cycle
			rnd = lcg_next();
			hazard_reg0 = rnd[19:16];
			modifies_flags0 = rnd[20];
			tag_hist.push_back('{reg_idx: hazard_reg0, modifies_flags: modifies_flags0});
			if (tag_hist.size() > 3)
				void'(tag_hist.pop_front());
			next_cycle();
			check_value("straight slot 0", taken.instr, pipeline_stage0);
			check_value("straight tag 1", tag_hist[tag_hist.size() - 1], hazard_tag1);
			if (tag_hist.size() == 3) begin
				check_value("straight tag 2", tag_hist[1], hazard_tag2);
				check_value("straight tag 3", tag_hist[0], hazard_tag3);
			end
			hist.push_back(taken);
			if (hist.size() > 5)
				void'(hist.pop_front());
			if (hist.size() == 5) begin
				check_value("straight slot 4", hist[0].instr, pipeline_stage4);
				check_value("straight pc_stage4", (16'(hist[0].addr) + 16'd1) * 16'd2,
					pc_stage4);
			end
		end
	endtask

	task automatic branch_to(input instr_t target);
		load_pc = 1'b1;
		new_pc = target;
		next_cycle();
		load_pc = 1'b0;
		check_value("branch slot 0", NOP_INSTRUCTION, pipeline_stage0);
		check_value("branch slot 1", NOP_INSTRUCTION, pipeline_stage1);
		check_value("branch slot 2", NOP_INSTRUCTION, pipeline_stage2);
		check_value("branch tags", 16'h0000, {hazard_tag1, hazard_tag2});
		check_value("branch request", target[15:1], cache_request_address);
		next_cycle();
		check_value("branch imm_reg", 16'h0000, imm_reg);
	endtask

	task automatic wait_for_slot1(input instr_t ins, output logic found);
		found = 1'b0;
		for (int i = 0; i < 12 && !found; i++) begin
			next_cycle();
			found = (pipeline_stage1 === ins);
		end
	endtask

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	initial begin
		#(TEST_CYCLES * 2 * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles", TEST_CYCLES * 2);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		instr_t held;
		hazard_tag_t held_tag;
		logic found;
		logic [31:0] rnd;

		RSTb = 1'b0;
		{hazard_1, hazard_2, hazard_3} = 3'b000;
		hazard_reg0 = R0;
		modifies_flags0 = 1'b0;
		cache_line = '0;
		cache_miss = 1'b0;
		mem = '{was_requested: 1'b0, success: 1'b1, bank_switch: 1'b0};
		load_pc = 1'b0;
		new_pc = '0;
		halt = 1'b0;
		interrupt = 1'b0;
		irq = 4'h0;
		interrupt_flag_set = 1'b0;
		interrupt_flag_clear = 1'b0;
		miss_mode = 1'b0;
		last_request = '0;
		checks = 0;
		errors = 0;
		misses = 0;
		lcg_state = 32'h8664_3668;
		for (int i = 0; i < 64; i++) begin
			program_mem[i] = 16'h4000 | (16'(i) * 16'h0101);
			rnd = lcg_next();
			miss_map[i] = rnd[16];
		end
		program_mem[40] = PREFIX_INSTR;
		program_mem[41] = USER_INSTR;

		repeat (2) @(posedge CLK);
		@(negedge CLK);
		RSTb = 1'b1;

		run_straight(4, 16);

		// Hazard k stalls slot 1 for 4 - k cycles
		for (int k = 1; k <= 3; k++) begin
			run_straight(4, 2);
			held = hist[hist.size() - 1].instr;
			hazard_reg0 = reg_idx_t'(k + 4);
			modifies_flags0 = 1'b1;
			held_tag = '{reg_idx: hazard_reg0, modifies_flags: modifies_flags0};
			{hazard_3, hazard_2, hazard_1} = 3'b001 << (k - 1);
			next_cycle();
			{hazard_3, hazard_2, hazard_1} = 3'b000;
			hazard_reg0 = R0;
			modifies_flags0 = 1'b0;
			check_value("hazard slot 1", held, pipeline_stage1);
			check_value("hazard tag 1", held_tag, hazard_tag1);
			repeat (4 - k) begin
				next_cycle();
				check_value("hazard hold slot 1", held, pipeline_stage1);
				check_value("hazard hold tag 1", held_tag, hazard_tag1);
				check_value("hazard bubble slot 2", NOP_INSTRUCTION, pipeline_stage2);
				check_value("hazard bubble tag 2", 16'h0000, hazard_tag2);
				check_value("hazard is_executing", 16'h0001, is_executing);
			end
		end

		miss_mode = 1'b1;
		repeat (24) begin
			next_cycle();
			if (miss_seen)
				check_value("miss slot 0", NOP_INSTRUCTION, pipeline_stage0);
		end
		miss_mode = 1'b0;
		assert (misses > 0) else begin
			errors++;
			$display("Miss test: the cache model never raised a miss");
		end
		branch_to(16'h0140);

		// Fault with slot 4 in flight
		run_straight(4, 6);
		mem = '{was_requested: 1'b1, success: 1'b0, bank_switch: 1'b1};
		next_cycle();
		mem = '{was_requested: 1'b0, success: 1'b1, bank_switch: 1'b1};
		check_value("replay slot 1", hist[0].instr, pipeline_stage1);
		check_value("replay slot 0", NOP_INSTRUCTION, pipeline_stage0);
		check_value("replay slot 2", NOP_INSTRUCTION, pipeline_stage2);
		check_value("replay slot 3", NOP_INSTRUCTION, pipeline_stage3);
		check_value("replay slot 4", NOP_INSTRUCTION, pipeline_stage4);
		check_value("replay tags", 16'h0000, {hazard_tag1, hazard_tag2, hazard_tag3});
		check_value("replay request", hist[1].addr, cache_request_address);
		repeat (6) begin
			next_cycle();
			check_value("replay hold slot 0", NOP_INSTRUCTION, pipeline_stage0);
		end
		mem.bank_switch = 1'b0;
		run_straight(4, 8);

		interrupt_flag_set = 1'b1;
		next_cycle();
		interrupt_flag_set = 1'b0;
		interrupt = 1'b1;
		irq = 4'h9;
		next_cycle();
		interrupt = 1'b0;
		check_value("interrupt slot 0", {12'h050, 4'h9}, pipeline_stage0);
		run_straight(4, 4);
		interrupt_flag_clear = 1'b1;
		next_cycle();
		interrupt_flag_clear = 1'b0;
		interrupt = 1'b1;
		next_cycle();
		interrupt = 1'b0;
		check_value("masked interrupt slot 0", taken.instr, pipeline_stage0);

		halt = 1'b1;
		next_cycle();
		halt = 1'b0;
		check_value("halt is_executing", 16'h0000, is_executing);
		repeat (3) begin
			next_cycle();
			check_value("halt hold is_executing", 16'h0000, is_executing);
		end
		interrupt = 1'b1;
		next_cycle();
		interrupt = 1'b0;
		check_value("wake is_executing", 16'h0001, is_executing);

		// Prefix sits at word 40 and its user at word 41
		branch_to(16'h0050);
		// Branching with the prefix in slot 1 must drop its payload
		wait_for_slot1(PREFIX_INSTR, found);
		assert (found) else begin
			errors++;
			$display("Immediate test: the prefix never reached slot 1");
		end
		branch_to(16'h0050);
		wait_for_slot1(USER_INSTR, found);
		assert (found) else begin
			errors++;
			$display("Immediate test: the instruction after the prefix never reached slot 1");
		end
		if (found) begin
			next_cycle();
			check_value("immediate imm_reg", {PREFIX_INSTR[11:0], USER_INSTR[3:0]}, imm_reg);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/cpu_isa_pkg.sv
// Instruction set types

`default_nettype none

`include "cpu_settings.svh"

package cpu_isa_pkg;

	typedef logic [`CPU_BITS-1:0] instr_t;
	typedef logic [`CPU_WORD_ADDR_BITS-1:0] word_addr_t;
	typedef logic [`CPU_REGISTER_BITS-1:0] reg_idx_t;

	localparam instr_t NOP_INSTRUCTION = '0;

	// Injected interrupt is INT_BASE followed by the irq number
	localparam logic [11:0] INT_BASE = 12'h050;

	// Opcode of the immediate prefix, bits 15:12
	localparam logic [3:0] IMM_PREFIX_OP = 4'h1;

	// Register 0 doubles as "no destination"
	localparam reg_idx_t R0 = '0;

	// Upper 12 bits of a 16-bit immediate carried by the prefix
	function automatic logic [11:0] imm_upper(instr_t ins);
		return ins[11:0];
	endfunction

	// Low nibble immediate of an ordinary instruction
	function automatic logic [3:0] imm_low(instr_t ins);
		return ins[3:0];
	endfunction

endpackage

`default_nettype wire

// File: source/cpu_pipe_pkg.sv
// Pipeline control types

`default_nettype none

package cpu_pipe_pkg;

	import cpu_isa_pkg::*;

	typedef enum logic [3:0] {
		st_halt,
		st_execute,
		st_wait_cache1,
		st_wait_cache2,
		st_stall_2,
		st_stall_3,
		st_stall_4,
		st_mem_stall1,
		st_mem_stall2,
		st_mem_stall3,
		st_mem_stall4
	} pipe_state_e;

	// One pipeline slot: instruction and the word address it came from
	typedef struct packed {
		instr_t instr;
		word_addr_t pc;
	} slot_t;

	typedef struct packed {
		reg_idx_t reg_idx;
		logic modifies_flags;
	} hazard_tag_t;

	// Line as returned by the instruction cache
	typedef struct packed {
		word_addr_t addr;
		logic spare;
		instr_t instr;
	} cache_line_t;

	typedef struct packed {
		logic was_requested;
		logic success;
		logic bank_switch;
	} mem_status_t;

	// Per-cycle sequencer decision
	typedef struct packed {
		pipe_state_e state;
		logic fetch_ok;
		logic int_take;
		logic replay;
		logic rewind;
	} pipe_ctl_t;

endpackage

`default_nettype wire

// File: source/cpu_pipeline.sv
// CPU pipeline controller

`timescale 1ns/1ps
`default_nettype none

module cpu_pipeline (
	input logic CLK,
	input logic RSTb,
	input logic hazard_1,
	input logic hazard_2,
	input logic hazard_3,
	input cpu_isa_pkg::reg_idx_t hazard_reg0,
	input logic modifies_flags0,
	input cpu_pipe_pkg::cache_line_t cache_line,
	input logic cache_miss,
	input cpu_pipe_pkg::mem_status_t mem,
	input logic load_pc,
	input cpu_isa_pkg::instr_t new_pc,
	input logic halt,
	input logic interrupt,
	input logic [3:0] irq,
	input logic interrupt_flag_set,
	input logic interrupt_flag_clear,
	output cpu_isa_pkg::instr_t pipeline_stage0,
	output cpu_isa_pkg::instr_t pipeline_stage1,
	output cpu_isa_pkg::instr_t pipeline_stage2,
	output cpu_isa_pkg::instr_t pipeline_stage3,
	output cpu_isa_pkg::instr_t pipeline_stage4,
	output cpu_isa_pkg::instr_t pc_stage4,
	output cpu_pipe_pkg::hazard_tag_t hazard_tag1,
	output cpu_pipe_pkg::hazard_tag_t hazard_tag2,
	output cpu_pipe_pkg::hazard_tag_t hazard_tag3,
	output cpu_isa_pkg::instr_t imm_reg,
	output cpu_isa_pkg::word_addr_t cache_request_address,
	output logic is_executing
);

	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	pipe_ctl_t ctl;
	hazard_tag_t tag0;
	word_addr_t rewind_pc;
	slot_t slot0;
	slot_t slot1;
	slot_t slot2;
	slot_t slot3;
	slot_t slot4;

	assign tag0 = '{reg_idx: hazard_reg0, modifies_flags: modifies_flags0};

	pipeline_sequencer u_sequencer (
		.CLK(CLK),
		.RSTb(RSTb),
		.hazard({hazard_3, hazard_2, hazard_1}),
		.cache_miss(cache_miss),
		.mem(mem),
		.halt(halt),
		.interrupt(interrupt),
		.interrupt_flag_set(interrupt_flag_set),
		.interrupt_flag_clear(interrupt_flag_clear),
		.load_pc(load_pc),
		.ctl(ctl),
		.is_executing(is_executing)
	);

	// Replay restarts fetch at the slot 3 instruction
	fetch_pc u_fetch_pc (
		.CLK(CLK),
		.RSTb(RSTb),
		.ctl(ctl),
		.load_pc(load_pc),
		.new_pc(new_pc),
		.replay_pc(slot3.pc),
		.request_addr(cache_request_address),
		.rewind_pc(rewind_pc)
	);

	pipeline_slots u_slots (
		.CLK(CLK),
		.RSTb(RSTb),
		.ctl(ctl),
		.load_pc(load_pc),
		.new_pc(new_pc),
		.line(cache_line),
		.irq(irq),
		.rewind_pc(rewind_pc),
		.tag0(tag0),
		.slot0(slot0),
		.slot1(slot1),
		.slot2(slot2),
		.slot3(slot3),
		.slot4(slot4),
		.tag1(hazard_tag1),
		.tag2(hazard_tag2),
		.tag3(hazard_tag3)
	);

	imm_tracker u_imm (
		.CLK(CLK),
		.RSTb(RSTb),
		.ctl(ctl),
		.load_pc(load_pc),
		.slot1_instr(slot1.instr),
		.imm(imm_reg)
	);

	assign pipeline_stage0 = slot0.instr;
	assign pipeline_stage1 = slot1.instr;
	assign pipeline_stage2 = slot2.instr;
	assign pipeline_stage3 = slot3.instr;
	assign pipeline_stage4 = slot4.instr;

	// Byte address of the instruction after slot 4
	assign pc_stage4 = {slot4.pc + word_addr_t'(1), 1'b0};

endmodule

`default_nettype wire

// File: source/cpu_settings.svh
// CPU width settings

`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data path and instruction width
`define CPU_BITS 16

// Instruction memory is addressed in 16-bit words
`define CPU_WORD_ADDR_BITS 15

// Register file index
`define CPU_REGISTER_BITS 4

`endif

// File: source/fetch_pc.sv
// Fetch program counter

`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module fetch_pc (
	input logic CLK,
	input logic RSTb,
	input cpu_pipe_pkg::pipe_ctl_t ctl,
	input logic load_pc,
	input cpu_isa_pkg::instr_t new_pc,
	input cpu_isa_pkg::word_addr_t replay_pc,
	output cpu_isa_pkg::word_addr_t request_addr,
	output cpu_isa_pkg::word_addr_t rewind_pc
);

	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	word_addr_t pc_q;
	word_addr_t pc_d;
	word_addr_t prev_q;
	word_addr_t prev_d;

	assign request_addr = pc_q;
	assign rewind_pc = prev_q;

	// Later assignments win
	always_comb begin
		pc_d = pc_q;
		prev_d = pc_q;
		if (ctl.state == st_execute)
			pc_d = pc_q + word_addr_t'(1);
		if (ctl.rewind) begin
			pc_d = prev_q;
			prev_d = prev_q;
		end
		// Branch target is a byte address
		if (load_pc) begin
			pc_d = new_pc[`CPU_BITS-1:1];
			prev_d = new_pc[`CPU_BITS-1:1];
		end
		if (ctl.replay) begin
			pc_d = replay_pc;
			prev_d = replay_pc;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pc_q <= '0;
			prev_q <= '0;
		end else begin
			pc_q <= pc_d;
			prev_q <= prev_d;
		end
	end

endmodule

`default_nettype wire

// File: source/imm_tracker.sv
// Immediate prefix tracker

`timescale 1ns/1ps
`default_nettype none

module imm_tracker (
	input logic CLK,
	input logic RSTb,
	input cpu_pipe_pkg::pipe_ctl_t ctl,
	input logic load_pc,
	input cpu_isa_pkg::instr_t slot1_instr,
	output cpu_isa_pkg::instr_t imm
);

	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	logic [11:0] prefix_q;
	logic [11:0] prefix_d;
	instr_t imm_q;
	instr_t imm_d;
	logic was_exec_q;
	logic load_pc_q;

	assign imm = imm_q;

	always_comb begin
		prefix_d = '0;
		// NOP between prefix and user keeps the payload
		if (slot1_instr == NOP_INSTRUCTION && !load_pc)
			prefix_d = prefix_q;
		if (slot1_instr[15:12] == IMM_PREFIX_OP)
			prefix_d = imm_upper(slot1_instr);

		imm_d = imm_q;
		if (was_exec_q)
			imm_d = {prefix_q, imm_low(slot1_instr)};

		// Possibly a stale prefix after a branch
		if (load_pc_q) begin
			prefix_d = '0;
			imm_d = '0;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			prefix_q <= '0;
			imm_q <= '0;
			was_exec_q <= 1'b0;
			load_pc_q <= 1'b0;
		end else begin
			prefix_q <= prefix_d;
			imm_q <= imm_d;
			was_exec_q <= (ctl.state == st_execute);
			load_pc_q <= load_pc;
		end
	end

endmodule

`default_nettype wire

// File: source/pipeline_sequencer.sv
// Pipeline sequencer

`timescale 1ns/1ps
`default_nettype none

module pipeline_sequencer (
	input logic CLK,
	input logic RSTb,
	input logic [2:0] hazard,
	input logic cache_miss,
	input cpu_pipe_pkg::mem_status_t mem,
	input logic halt,
	input logic interrupt,
	input logic interrupt_flag_set,
	input logic interrupt_flag_clear,
	input logic load_pc,
	output cpu_pipe_pkg::pipe_ctl_t ctl,
	output logic is_executing
);

	import cpu_pipe_pkg::*;

	pipe_state_e state_q;
	pipe_state_e state_d;
	pipe_state_e prev_state_q;
	logic load_pc_q;
	logic int_flag_q;
	logic mem_fault;
	logic replay_state;

	assign mem_fault = mem.was_requested && !mem.success;

	// States from which a failed data access can force a replay
	always_comb begin
		case (state_q)
			st_execute, st_wait_cache1, st_wait_cache2,
			st_stall_2, st_stall_3, st_stall_4, st_mem_stall4:
				replay_state = 1'b1;
			default:
				replay_state = 1'b0;
		endcase
	end

	always_comb begin
		ctl.state = state_q;
		ctl.fetch_ok = !cache_miss && (state_q == prev_state_q) && !load_pc_q;
		ctl.int_take = int_flag_q && interrupt && (state_q == st_execute);
		ctl.replay = mem_fault && replay_state;
		ctl.rewind = (state_q == st_wait_cache1) || (state_q == st_mem_stall1);
		if (state_q == st_execute && ((|hazard) || cache_miss || ctl.int_take))
			ctl.rewind = 1'b1;
	end

	assign is_executing = (state_q != st_halt);

	// Hazards ranked by distance, then miss, then halt
	always_comb begin
		state_d = state_q;
		case (state_q)
			st_halt:
				if (interrupt)
					state_d = st_execute;
			st_execute: begin
				if (hazard[0])
					state_d = st_stall_2;
				else if (hazard[1])
					state_d = st_stall_3;
				else if (hazard[2])
					state_d = st_stall_4;
				else if (cache_miss)
					state_d = st_wait_cache1;
				else if (halt)
					state_d = st_halt;
			end
			// PC returns to the rewind address here
			st_wait_cache1:
				state_d = st_wait_cache2;
			st_wait_cache2:
				if (!cache_miss)
					state_d = st_execute;
			st_stall_2:
				state_d = st_stall_3;
			st_stall_3:
				state_d = st_stall_4;
			st_stall_4:
				state_d = st_execute;
			st_mem_stall1:
				state_d = st_mem_stall2;
			st_mem_stall2:
				state_d = st_mem_stall3;
			st_mem_stall3:
				state_d = st_mem_stall4;
			st_mem_stall4:
				if (!mem.bank_switch)
					state_d = st_execute;
			default:
				state_d = st_execute;
		endcase

		// Memory fault trumps everything
		if (ctl.replay)
			state_d = st_mem_stall1;
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state_q <= st_execute;
			prev_state_q <= st_halt;
			load_pc_q <= 1'b0;
			int_flag_q <= 1'b0;
		end else begin
			state_q <= state_d;
			prev_state_q <= state_q;
			load_pc_q <= load_pc;
			if (interrupt_flag_set)
				int_flag_q <= 1'b1;
			else if (interrupt_flag_clear)
				int_flag_q <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: source/pipeline_slots.sv
// Instruction and hazard tag slots

`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module pipeline_slots (
	input logic CLK,
	input logic RSTb,
	input cpu_pipe_pkg::pipe_ctl_t ctl,
	input logic load_pc,
	input cpu_isa_pkg::instr_t new_pc,
	input cpu_pipe_pkg::cache_line_t line,
	input logic [3:0] irq,
	input cpu_isa_pkg::word_addr_t rewind_pc,
	input cpu_pipe_pkg::hazard_tag_t tag0,
	output cpu_pipe_pkg::slot_t slot0,
	output cpu_pipe_pkg::slot_t slot1,
	output cpu_pipe_pkg::slot_t slot2,
	output cpu_pipe_pkg::slot_t slot3,
	output cpu_pipe_pkg::slot_t slot4,
	output cpu_pipe_pkg::hazard_tag_t tag1,
	output cpu_pipe_pkg::hazard_tag_t tag2,
	output cpu_pipe_pkg::hazard_tag_t tag3
);

	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	localparam hazard_tag_t NO_TAG = '{reg_idx: R0, modifies_flags: 1'b0};

	slot_t slot_q [0:4];
	slot_t slot_d [0:4];
	hazard_tag_t tag_q [1:3];
	hazard_tag_t tag_d [1:3];
	word_addr_t branch_pc;
	logic slot0_prefix;

	assign branch_pc = new_pc[`CPU_BITS-1:1];
	assign slot0_prefix = (slot_q[0].instr[`CPU_BITS-1:`CPU_BITS-4] == IMM_PREFIX_OP);

	always_comb begin
		slot_d = slot_q;
		tag_d = tag_q;

		case (ctl.state)
			st_execute: begin
				if (ctl.int_take) begin
					slot_d[0].instr = {INT_BASE, irq};
					// Return to the prefix so the immediate is rebuilt
					slot_d[0].pc = slot0_prefix ? rewind_pc - word_addr_t'(2) : rewind_pc;
				end else if (ctl.fetch_ok) begin
					slot_d[0].instr = line.instr;
					slot_d[0].pc = line.addr;
				end else begin
					slot_d[0] = '{instr: NOP_INSTRUCTION, pc: rewind_pc};
				end
				for (int i = 1; i < 5; i++)
					slot_d[i] = slot_q[i-1];
				tag_d[1] = tag0;
				tag_d[2] = tag_q[1];
				tag_d[3] = tag_q[2];
			end
			st_wait_cache1, st_wait_cache2, st_stall_2, st_stall_3, st_stall_4: begin
				// Slot 1 waits while a bubble goes down behind it
				slot_d[0] = '{instr: NOP_INSTRUCTION, pc: rewind_pc};
				slot_d[2] = '{instr: NOP_INSTRUCTION, pc: slot_q[1].pc};
				slot_d[3] = slot_q[2];
				slot_d[4] = slot_q[3];
				tag_d[2] = NO_TAG;
				tag_d[3] = tag_q[2];
			end
			st_mem_stall1, st_mem_stall2, st_mem_stall3, st_mem_stall4: begin
				slot_d[0] = '{instr: NOP_INSTRUCTION, pc: slot_q[0].pc};
				for (int i = 1; i < 5; i++)
					slot_d[i] = slot_q[i-1];
				tag_d[1] = tag0;
				tag_d[2] = tag_q[1];
				tag_d[3] = tag_q[2];
			end
			default: ;
		endcase

		// Branch flushes the front three slots
		if (load_pc) begin
			for (int i = 0; i < 3; i++)
				slot_d[i] = '{instr: NOP_INSTRUCTION, pc: branch_pc};
			tag_d[1] = NO_TAG;
			tag_d[2] = NO_TAG;
		end

		// Faulting access in slot 4 restarts from slot 1
		if (ctl.replay) begin
			slot_d[0] = '{instr: NOP_INSTRUCTION, pc: slot_q[3].pc};
			slot_d[1] = slot_q[4];
			for (int i = 2; i < 5; i++)
				slot_d[i] = '{instr: NOP_INSTRUCTION, pc: slot_q[4].pc};
			for (int i = 1; i < 4; i++)
				tag_d[i] = NO_TAG;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < 5; i++)
				slot_q[i] <= '{instr: NOP_INSTRUCTION, pc: '0};
			for (int i = 1; i < 4; i++)
				tag_q[i] <= NO_TAG;
		end else begin
			slot_q <= slot_d;
			tag_q <= tag_d;
		end
	end

	assign slot0 = slot_q[0];
	assign slot1 = slot_q[1];
	assign slot2 = slot_q[2];
	assign slot3 = slot_q[3];
	assign slot4 = slot_q[4];
	assign tag1 = tag_q[1];
	assign tag2 = tag_q[2];
	assign tag3 = tag_q[3];

endmodule

`default_nettype wire

// File: tb.f
+incdir+source
source/cpu_isa_pkg.sv
source/cpu_pipe_pkg.sv
source/pipeline_sequencer.sv
source/fetch_pc.sv
source/pipeline_slots.sv
source/imm_tracker.sv
source/cpu_pipeline.sv
dv/cpu_pipeline_tb.sv
